// File: fp_defs.svh
// Q8.8 word format, unit latency and divider step count; include before any package or module.
`ifndef FP_DEFS_SVH
`define FP_DEFS_SVH

// *************************************************************************
// Number format.
// *************************************************************************

// Total word width.
`define FP_WIDTH 16

// Bits below the binary point.
`define FP_FRAC_WIDTH 8

// Bits above the binary point.
`define FP_INT_WIDTH 8

// *************************************************************************
// Unit timing.
// *************************************************************************

// Cycles from a sampled multiply request to its done pulse.
`define FP_MUL_LATENCY 3

// One restoring step per quotient bit of the dividend widened by the fraction.
`define FP_DIV_ITERATIONS (`FP_WIDTH + `FP_FRAC_WIDTH)

`endif

// File: fp_types_pkg.sv
// Number-format types shared by the multiplier, the divider and the top level of the unit.
`include "fp_defs.svh"

package fp_types_pkg;

  // *************************************************************************
  // Data words.
  // *************************************************************************

  // One operand or result in Q8.8.
  typedef logic [`FP_WIDTH-1:0] fp_word_t;

  // Full product, and the divider accumulator.
  typedef logic [2*`FP_WIDTH-1:0] fp_wide_t;

  // *************************************************************************
  // Interpretation.
  // *************************************************************************

  // Selects how the operand words are read.
  typedef enum logic {
    FP_UNSIGNED = 1'b0,
    FP_SIGNED   = 1'b1
  } fp_mode_t;

endpackage

// File: arith_ctrl_pkg.sv
// Operation-select and divider-control types for the top level and the divide core.
`include "fp_defs.svh"

package arith_ctrl_pkg;

  // Which unit a go strobe is steered to.
  typedef enum logic {
    OP_MUL = 1'b0,
    OP_DIV = 1'b1
  } arith_op_t;

  // Iteration counter of the divide core.
  typedef logic [$clog2(`FP_DIV_ITERATIONS)-1:0] div_count_t;

endpackage

// File: arith_req_if.sv
// One operation request from the top level to an arithmetic unit, single-cycle strobe.
interface arith_req_if
  import fp_types_pkg::*;
();

  // Mode and operands are valid only in the strobe cycle.
  logic     strobe;
  fp_mode_t mode;
  fp_word_t left;
  fp_word_t right;

  modport source (
    output strobe,
    output mode,
    output left,
    output right
  );

  modport sink (
    input strobe,
    input mode,
    input left,
    input right
  );

endinterface

// File: div_core_if.sv
// Link between the signed divide wrapper and the unsigned divide core.
interface div_core_if
  import fp_types_pkg::*;
();

  logic     start;
  fp_word_t dividend;
  fp_word_t divisor;
  fp_word_t quotient;
  logic     done;
  logic     busy;

  // The core looks at start only while busy is low.
  modport wrapper (
    output start,
    output dividend,
    output divisor,
    input  quotient,
    input  done,
    input  busy
  );

  modport core (
    input  start,
    input  dividend,
    input  divisor,
    output quotient,
    output done,
    output busy
  );

endinterface

// File: fp_mul_pipe.sv
// Three-stage Q8.8 multiplier in signed or unsigned mode; takes a new request every cycle.
`include "fp_defs.svh"

module fp_mul_pipe
  import fp_types_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  arith_req_if.sink req,
  output logic      done,
  output fp_word_t  result
);

  fp_wide_t                   left_ext;
  fp_wide_t                   right_ext;
  fp_wide_t                   prod;
  logic [`FP_MUL_LATENCY-1:0] vld;

  // One valid bit per stage.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld <= '0;
    end else begin
      vld <= {vld[`FP_MUL_LATENCY-2:0], req.strobe};
    end
  end

  assign done = vld[`FP_MUL_LATENCY-1];

  // *************************************************************************
  // Stage one and two.
  // *************************************************************************

  always_ff @(posedge clk) begin
    if (req.strobe) begin
      if (req.mode == FP_SIGNED) begin
        left_ext  <= {{`FP_WIDTH{req.left[`FP_WIDTH-1]}}, req.left};
        right_ext <= {{`FP_WIDTH{req.right[`FP_WIDTH-1]}}, req.right};
      end else begin
        left_ext  <= {{`FP_WIDTH{1'b0}}, req.left};
        right_ext <= {{`FP_WIDTH{1'b0}}, req.right};
      end
    end
  end

  // Low half of the extended product is exact for both modes.
  always_ff @(posedge clk) begin
    if (vld[0]) begin
      prod <= left_ext * right_ext;
    end
  end

  // *************************************************************************
  // Stage three.
  // *************************************************************************

  // Drop the extra fraction bits and the overflowed integer bits.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else if (vld[1]) begin
      result <= prod[2*`FP_WIDTH-`FP_INT_WIDTH-1:`FP_WIDTH-`FP_INT_WIDTH];
    end
  end

endmodule

// File: fp_div_core.sv
// Unsigned Q8.8 restoring divider; one operation at a time, one quotient bit per cycle.
`include "fp_defs.svh"

module fp_div_core
  import fp_types_pkg::*;
  import arith_ctrl_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  div_core_if.core core
);

  fp_wide_t   acc;
  fp_wide_t   quo;
  fp_word_t   divisor;
  div_count_t count;
  logic       accept;
  logic       last;
  fp_wide_t   acc_shift;
  fp_wide_t   acc_next;
  fp_wide_t   quo_next;

  assign accept = core.start && !core.busy;
  assign last   = core.busy && (count == div_count_t'(`FP_DIV_ITERATIONS - 1));

  // *************************************************************************
  // One restoring step.
  // *************************************************************************

  // The top bit of quo feeds the accumulator while quotient bits enter at the bottom.
  always_comb begin
    acc_shift = {acc[2*`FP_WIDTH-2:0], quo[2*`FP_WIDTH-1]};
    if (acc_shift >= {{`FP_WIDTH{1'b0}}, divisor}) begin
      acc_next = acc_shift - {{`FP_WIDTH{1'b0}}, divisor};
      quo_next = {quo[2*`FP_WIDTH-2:0], 1'b1};
    end else begin
      acc_next = acc_shift;
      quo_next = {quo[2*`FP_WIDTH-2:0], 1'b0};
    end
  end

  // *************************************************************************
  // Control.
  // *************************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      core.busy     <= 1'b0;
      core.done     <= 1'b0;
      core.quotient <= '0;
      count         <= '0;
    end else begin
      core.done <= last;
      if (accept) begin
        core.busy <= 1'b1;
        count     <= '0;
      end else if (last) begin
        // Final step goes straight to the output.
        core.busy     <= 1'b0;
        core.quotient <= quo_next[`FP_WIDTH-1:0];
      end else if (core.busy) begin
        count <= count + 1'b1;
      end
    end
  end

  // Dividend sits at the top with the fraction zeros behind it.
  always_ff @(posedge clk) begin
    if (accept) begin
      acc     <= '0;
      quo     <= {core.dividend, {`FP_WIDTH{1'b0}}};
      divisor <= core.divisor;
    end else if (core.busy) begin
      acc <= acc_next;
      quo <= quo_next;
    end
  end

endmodule

// File: fp_div_signed.sv
// Signed Q8.8 divide; divides the magnitudes in the unsigned core and fixes the quotient sign.
`include "fp_defs.svh"

module fp_div_signed
  import fp_types_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  arith_req_if.sink req,
  output logic      done,
  output fp_word_t  result,
  output logic      busy
);

  div_core_if div_if ();

  logic left_neg;
  logic right_neg;
  logic neg_pending;
  logic neg_result;
  logic neg_sel;

  // Raw words pass through in unsigned mode.
  assign left_neg  = (req.mode == FP_SIGNED) && req.left[`FP_WIDTH-1];
  assign right_neg = (req.mode == FP_SIGNED) && req.right[`FP_WIDTH-1];

  assign div_if.start    = req.strobe;
  assign div_if.dividend = left_neg ? fp_word_t'(-req.left) : req.left;
  assign div_if.divisor  = right_neg ? fp_word_t'(-req.right) : req.right;

  // *************************************************************************
  // Quotient sign.
  // *************************************************************************

  // Pending flag for the running divide; result flag for the quotient on display.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      neg_pending <= 1'b0;
      neg_result  <= 1'b0;
    end else begin
      if (req.strobe && !div_if.busy) begin
        neg_pending <= left_neg ^ right_neg;
      end
      if (div_if.done) begin
        neg_result <= neg_pending;
      end
    end
  end

  // In the done cycle the pending flag still belongs to the new quotient.
  assign neg_sel = div_if.done ? neg_pending : neg_result;
  assign result  = neg_sel ? fp_word_t'(-div_if.quotient) : div_if.quotient;
  assign done    = div_if.done;
  assign busy    = div_if.busy;

  fp_div_core fp_div_core_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .core   (div_if.core)
  );

endmodule

// File: fp_arith_unit.sv
// RTL top level of the Q8.8 arithmetic unit; steers each go strobe to the multiplier or divider.
module fp_arith_unit
  import fp_types_pkg::*;
  import arith_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      go,
  input  arith_op_t op,
  input  fp_mode_t  mode,
  input  fp_word_t  left,
  input  fp_word_t  right,
  output logic      mul_done,
  output fp_word_t  mul_result,
  output logic      div_done,
  output fp_word_t  div_result,
  output logic      div_busy
);

  arith_req_if mul_req ();
  arith_req_if div_req ();

  // *************************************************************************
  // Request steering.
  // *************************************************************************

  // Only the strobe is steered; both units see the same operands.
  assign mul_req.strobe = go && (op == OP_MUL);
  assign mul_req.mode   = mode;
  assign mul_req.left   = left;
  assign mul_req.right  = right;

  assign div_req.strobe = go && (op == OP_DIV);
  assign div_req.mode   = mode;
  assign div_req.left   = left;
  assign div_req.right  = right;

  // *************************************************************************
  // Units.
  // *************************************************************************

  fp_mul_pipe fp_mul_pipe_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (mul_req.sink),
    .done   (mul_done),
    .result (mul_result)
  );

  // A divide request while busy is dropped inside the core.
  fp_div_signed fp_div_signed_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (div_req.sink),
    .done   (div_done),
    .result (div_result),
    .busy   (div_busy)
  );

endmodule

// File: fp_arith_unit_sva.sv
// Timing and strobe checks for the arithmetic unit; bound into the RTL top level by the bind below.
`include "fp_defs.svh"

module fp_arith_unit_sva
  import fp_types_pkg::*;
  import arith_ctrl_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input logic      go,
  input arith_op_t op,
  input logic      mul_done,
  input fp_word_t  mul_result,
  input logic      div_done,
  input fp_word_t  div_result,
  input logic      div_busy
);

  int   error_count = 0;
  logic mul_go;
  logic div_accept;

  assign mul_go     = go && (op == OP_MUL);
  assign div_accept = go && (op == OP_DIV) && !div_busy;

  mul_latency_a : assert property (@(posedge clk) disable iff (!arst_n)
    mul_done == $past(mul_go, `FP_MUL_LATENCY))
  else begin
    error_count++;
    $error("mul_done does not follow a multiply request by the multiply latency");
  end

  // Back-to-back pulses only when the next request was made.
  mul_single_a : assert property (@(posedge clk) disable iff (!arst_n)
    (mul_done && !$past(mul_go, `FP_MUL_LATENCY - 1)) |=> !mul_done)
  else begin
    error_count++;
    $error("mul_done lasted more than one cycle");
  end

  div_single_a : assert property (@(posedge clk) disable iff (!arst_n)
    div_done |=> !div_done)
  else begin
    error_count++;
    $error("div_done lasted more than one cycle");
  end

  div_latency_a : assert property (@(posedge clk) disable iff (!arst_n)
    div_accept |=> div_busy [*`FP_DIV_ITERATIONS] ##1 (div_done && !div_busy))
  else begin
    error_count++;
    $error("div_done or div_busy off their timing after an accepted divide");
  end

  reset_low_a : assert property (@(posedge clk)
    !arst_n |-> (!mul_done && !div_done && !div_busy && mul_result == '0 && div_result == '0))
  else begin
    error_count++;
    $error("outputs not low during reset");
  end

endmodule

bind fp_arith_unit fp_arith_unit_sva fp_arith_unit_sva_inst (
  .clk        (clk),
  .arst_n     (arst_n),
  .go         (go),
  .op         (op),
  .mul_done   (mul_done),
  .mul_result (mul_result),
  .div_done   (div_done),
  .div_result (div_result),
  .div_busy   (div_busy)
);

// File: tb_fp_arith_unit.sv
// Testbench for the Q8.8 arithmetic unit; reads the case file, drives the DUT and checks each result.
`include "fp_defs.svh"

module tb_fp_arith_unit
  import fp_types_pkg::*;
  import arith_ctrl_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 8;
  localparam int DRAIN_LIMIT  = 40;

  logic      clk;
  logic      arst_n;
  logic      go;
  arith_op_t op;
  fp_mode_t  mode;
  fp_word_t  left;
  fp_word_t  right;
  logic      mul_done;
  fp_word_t  mul_result;
  logic      div_done;
  fp_word_t  div_result;
  logic      div_busy;

  arith_op_t case_op[$];
  fp_mode_t  case_mode[$];
  fp_word_t  case_left[$];
  fp_word_t  case_right[$];
  fp_word_t  case_exp[$];
  logic      case_flow[$];
  logic      cases_loaded = 1'b0;

  // Outstanding multiplies, oldest first.
  fp_word_t  mul_exp_q[$];
  int        mul_cyc_q[$];
  int        mul_case_q[$];
  fp_word_t  mon_exp;
  int        mon_cyc;
  int        mon_case;
  logic      busy_exp;

  logic      div_pending = 1'b0;
  fp_word_t  div_exp;
  int        div_cyc;
  int        div_case;
  int        ignore_case = -1;
  int        ignore_strays;
  int        div_strays = 0;

  int        cycle = 0;
  int        pass_count = 0;
  int        fail_count = 0;

  fp_arith_unit fp_arith_unit_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .go         (go),
    .op         (op),
    .mode       (mode),
    .left       (left),
    .right      (right),
    .mul_done   (mul_done),
    .mul_result (mul_result),
    .div_done   (div_done),
    .div_result (div_result),
    .div_busy   (div_busy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // *************************************************************************
  // Case file and compare tasks.
  // *************************************************************************

  task automatic load_cases();
    int       fd;
    int       n;
    int       c_op;
    int       c_mode;
    int       c_flow;
    fp_word_t c_left;
    fp_word_t c_right;
    fp_word_t c_exp;
    string    line;
    fd = $fopen("fp_arith_cases.txt", "r");
    if (fd == 0) begin
      fail_count++;
      $display("could not open the case file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h", c_op, c_mode, c_left, c_right, c_exp, c_flow);
          if (n == 6) begin
            case_op.push_back(arith_op_t'(c_op[0]));
            case_mode.push_back(fp_mode_t'(c_mode[0]));
            case_left.push_back(c_left);
            case_right.push_back(c_right);
            case_exp.push_back(c_exp);
            case_flow.push_back(c_flow[0]);
          end
        end
      end
      $fclose(fd);
    end
    cases_loaded = 1'b1;
  endtask

  task automatic check_mul(input int idx, input fp_word_t expected, input fp_word_t actual);
    if (actual === expected) begin
      pass_count++;
      $display("case %0d pass: mul_result %h", idx, actual);
    end else begin
      fail_count++;
      $display("mismatch at %0t: mul_result expected %h actual %h in case %0d",
               $time, expected, actual, idx);
    end
  endtask

  task automatic check_div(input int idx, input fp_word_t expected, input fp_word_t actual);
    if (actual === expected) begin
      pass_count++;
      $display("case %0d pass: div_result %h", idx, actual);
    end else begin
      fail_count++;
      $display("mismatch at %0t: div_result expected %h actual %h in case %0d",
               $time, expected, actual, idx);
    end
  endtask

  task automatic check_busy(input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_count++;
      $display("mismatch at %0t: div_busy expected %b actual %b", $time, expected, actual);
    end
  endtask

  // *************************************************************************
  // Stimulus.
  // *************************************************************************

  task automatic issue_case(input int idx);
    go    = 1'b1;
    op    = case_op[idx];
    mode  = case_mode[idx];
    left  = case_left[idx];
    right = case_right[idx];
    if (case_op[idx] == OP_MUL) begin
      mul_exp_q.push_back(case_exp[idx]);
      mul_cyc_q.push_back(cycle);
      mul_case_q.push_back(idx);
    end else if (div_pending) begin
      // Divider still busy, so the request must be dropped.
      ignore_case   = idx;
      ignore_strays = div_strays;
    end else begin
      div_pending = 1'b1;
      div_exp     = case_exp[idx];
      div_cyc     = cycle;
      div_case    = idx;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((mul_exp_q.size() != 0 || div_pending) && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    // Quiet cycles so that a stray done pulse still shows up.
    if (ignore_case >= 0) begin
      // A dropped request that ran anyway would finish one divide later.
      repeat (`FP_DIV_ITERATIONS + 2) @(posedge clk);
    end else begin
      repeat (2) @(posedge clk);
    end
    #DRIVE_DELAY;
    if (ignore_case >= 0) begin
      if (div_strays != ignore_strays) begin
        fail_count++;
        $display("case %0d: divide request while busy produced an extra div_done", ignore_case);
      end else begin
        check_div(ignore_case, div_exp, div_result);
      end
      ignore_case = -1;
    end
  endtask

  initial begin
    arst_n = 1'b1;
    go     = 1'b0;
    op     = OP_MUL;
    mode   = FP_UNSIGNED;
    left   = '0;
    right  = '0;
    load_cases();
    #DRIVE_DELAY;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    for (int i = 0; i < case_op.size(); i++) begin
      issue_case(i);
      @(posedge clk);
      #DRIVE_DELAY;
      go = 1'b0;
      if (case_flow[i]) begin
        drain();
      end
    end
    drain();
    if (mul_exp_q.size() != 0) begin
      fail_count++;
      $display("%0d multiply requests never produced mul_done", mul_exp_q.size());
    end
    if (div_pending) begin
      fail_count++;
      $display("divide request of case %0d never produced div_done", div_case);
    end
    if (fp_arith_unit_inst.fp_arith_unit_sva_inst.error_count != 0) begin
      fail_count += fp_arith_unit_inst.fp_arith_unit_sva_inst.error_count;
      $display("%0d assertion failures in the timing checks",
               fp_arith_unit_inst.fp_arith_unit_sva_inst.error_count);
    end
    $display("passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // *************************************************************************
  // Result monitor, sampled mid-cycle.
  // *************************************************************************

  always @(negedge clk) begin
    // Busy from the cycle after the request up to the done cycle.
    busy_exp = div_pending && (cycle != div_cyc) && !div_done;
    if (arst_n) begin
      check_busy(busy_exp, div_busy);
    end
    if (arst_n && mul_done) begin
      if (mul_exp_q.size() == 0) begin
        fail_count++;
        $display("%0t: mul_done pulsed with no multiply outstanding", $time);
      end else begin
        mon_exp  = mul_exp_q.pop_front();
        mon_cyc  = mul_cyc_q.pop_front();
        mon_case = mul_case_q.pop_front();
        if (cycle - mon_cyc != `FP_MUL_LATENCY) begin
          fail_count++;
          $display("%0t: case %0d mul_done came %0d cycles after its request",
                   $time, mon_case, cycle - mon_cyc);
        end
        check_mul(mon_case, mon_exp, mul_result);
      end
    end
    if (arst_n && div_done) begin
      if (!div_pending) begin
        div_strays++;
        fail_count++;
        $display("%0t: div_done pulsed with no divide outstanding", $time);
      end else begin
        if (cycle - div_cyc != `FP_DIV_ITERATIONS + 1) begin
          fail_count++;
          $display("%0t: case %0d div_done came %0d cycles after its request",
                   $time, div_case, cycle - div_cyc);
        end
        check_div(div_case, div_exp, div_result);
        div_pending = 1'b0;
      end
    end
  end

  // Watchdog sized from the case count.
  initial begin
    wait (cases_loaded);
    #(case_op.size() * 30 * CLK_PERIOD + 2000);
    $display("timeout: the run did not finish within the time allowed for %0d cases",
             case_op.size());
    $display("tests failed");
    $finish;
  end

endmodule

// File: fp_arith_cases.txt
# op mode left right expected flow, all hex; op 0 multiply 1 divide, mode 0 unsigned 1 signed
# flow 1 waits for every outstanding result before the next case, flow 0 issues it next cycle
0 0 0180 0200 0300 1
0 0 0080 0080 0040 1
0 0 2080 1100 2880 1
0 0 ff00 0180 7e80 1
0 0 0100 abcd abcd 1
0 1 ff00 0180 fe80 1
0 1 fe80 0280 fc40 1
0 1 fe00 fd80 0500 1
0 1 ffc0 ff80 0020 1
0 1 ffff 0080 ffff 1
0 0 0200 0300 0600 0
0 0 0340 0100 0340 0
0 1 ff00 ff00 0100 0
0 0 00c0 0400 0300 0
0 1 0100 8000 8000 0
0 0 0a00 0a00 6400 1
1 0 0600 0200 0300 1
1 0 0100 0300 0055 1
1 0 0700 0080 0e00 1
1 0 ff00 0080 fe00 1
1 0 0280 0400 00a0 1
1 1 0500 0200 0280 1
1 1 fb00 0200 fd80 1
1 1 0100 fd00 ffab 1
1 1 f900 ff80 0e00 1
1 0 0900 0300 0300 0
1 0 0400 0100 0400 0
0 0 0300 0300 0900 0
0 1 ff00 0300 fd00 1

// File: verilog.f
+incdir+.
fp_types_pkg.sv
arith_ctrl_pkg.sv
arith_req_if.sv
div_core_if.sv
fp_mul_pipe.sv
fp_div_core.sv
fp_div_signed.sv
fp_arith_unit.sv
fp_arith_unit_sva.sv
tb_fp_arith_unit.sv
